//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := mmu_tb
FILELIST  := mmu.f
OBJ_DIR   := obj_dir
RUN_ARGS  := +verilator+error+limit+100
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- mmu.f
verilog/mmu_addr_pkg.sv
verilog/mmu_pte_pkg.sv
verilog/mmu_ifs.sv
verilog/mmu_tlb.sv
verilog/mmu_ptw.sv
verilog/mmu_ctrl.sv
verilog/mmu_top.sv
testbench/mmu_assertions.sv
testbench/mmu_tb.sv

//--- testbench/mmu_assertions.sv
//////////////////////////////////////////////////////////////////////
// MMU handshake assertions
// Protocol rules for the requester and page table ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module mmu_assertions (
  input logic                 clk_i,
  input logic                 reset_i,
  input logic                 req_i,
  input logic                 ack_o,
  input logic                 fault_o,
  input mmu_addr_pkg::paddr_t paddr_o,
  input logic                 pt_req_o,
  input logic                 pt_ack_i
);

  int fail_count = 0;

  ack_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(ack_o) |-> $past(req_i))
    else begin
      $error("ack_o rose without req_i");
      fail_count++;
    end

  // Ack drops only after the requester has let go
  ack_drop_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(ack_o) |-> !$past(req_i))
    else begin
      $error("ack_o fell while req_i was still high");
      fail_count++;
    end

  pt_req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    pt_req_o && !pt_ack_i |=> pt_req_o)
    else begin
      $error("pt_req_o dropped before pt_ack_i");
      fail_count++;
    end

  fault_zero_addr: assert property (@(posedge clk_i) disable iff (reset_i)
    fault_o |-> paddr_o == '0)
    else begin
      $error("paddr_o not zero while fault_o is high");
      fail_count++;
    end

endmodule

bind mmu_top mmu_assertions assertions_i (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .req_i    (req_i),
  .ack_o    (ack_o),
  .fault_o  (fault_o),
  .paddr_o  (paddr_o),
  .pt_req_o (pt_req_o),
  .pt_ack_i (pt_ack_i)
);

//--- testbench/mmu_tb.sv
//////////////////////////////////////////////////////////////////////
// MMU testbench
// Directed load and store translations against a page table memory
// model with random response delay, plus a run watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module mmu_tb;

  localparam int TLB_ENTRIES     = 4;
  localparam int CLK_PERIOD      = 100;
  localparam int WATCHDOG_CYCLES = 40 * 60;

  localparam mmu_addr_pkg::ppn_t ROOT_PPN = 20'h00080;
  localparam logic [7:0] FL_V = 8'h01;
  localparam logic [7:0] FL_R = 8'h02;
  localparam logic [7:0] FL_W = 8'h04;

  logic                 clk_i;
  logic                 reset_i;
  logic                 translation_en_i;
  mmu_addr_pkg::ppn_t   satp_ppn_i;
  logic                 flush_i;
  logic                 req_i;
  mmu_addr_pkg::vaddr_t vaddr_i;
  logic                 store_i;
  logic                 ack_o;
  mmu_addr_pkg::paddr_t paddr_o;
  logic                 fault_o;
  logic                 pt_req_o;
  mmu_addr_pkg::paddr_t pt_addr_o;
  logic                 pt_ack_i;
  logic [31:0]          pt_data_i;

  // Page table contents by byte address
  logic [31:0] pt_mem [logic [31:0]];
  int          pt_reads;
  int          checks;
  int          errors;
  integer      seed = 32'h4247_66eb;

  mmu_top #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) mmu_top_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .translation_en_i (translation_en_i),
    .satp_ppn_i       (satp_ppn_i),
    .flush_i          (flush_i),
    .req_i            (req_i),
    .vaddr_i          (vaddr_i),
    .store_i          (store_i),
    .ack_o            (ack_o),
    .paddr_o          (paddr_o),
    .fault_o          (fault_o),
    .pt_req_o         (pt_req_o),
    .pt_addr_o        (pt_addr_o),
    .pt_ack_i         (pt_ack_i),
    .pt_data_i        (pt_data_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic mmu_addr_pkg::paddr_t table_addr(mmu_addr_pkg::ppn_t ppn,
                                                      logic [9:0] idx);
    return 32'(ppn) * 32'd4096 + 32'(idx) * 32'd4;
  endfunction

  function automatic logic [31:0] leaf_pte(mmu_addr_pkg::ppn_t ppn, logic [7:0] flags);
    return {ppn, 4'h0, flags};
  endfunction

  function automatic mmu_addr_pkg::vaddr_t make_va(logic [9:0] vpn1, logic [9:0] vpn0,
                                                   logic [11:0] offset);
    return {vpn1, vpn0, offset};
  endfunction

  function automatic mmu_addr_pkg::paddr_t page_addr(mmu_addr_pkg::ppn_t ppn,
                                                     mmu_addr_pkg::vaddr_t va);
    return 32'(ppn) * 32'd4096 + 32'(va.offset);
  endfunction

  // Missing words read as zero
  function automatic logic [31:0] mem_read(mmu_addr_pkg::paddr_t addr);
    if (pt_mem.exists(addr)) begin
      return pt_mem[addr];
    end
    return '0;
  endfunction

  // Pointer at level 1, leaf at level 0
  task automatic map_page(mmu_addr_pkg::vaddr_t va, mmu_addr_pkg::ppn_t l0_ppn,
                          mmu_addr_pkg::ppn_t leaf_ppn, logic [7:0] flags);
    pt_mem[table_addr(ROOT_PPN, va.vpn1)] = leaf_pte(l0_ppn, FL_V);
    pt_mem[table_addr(l0_ppn, va.vpn0)]   = leaf_pte(leaf_ppn, flags);
  endtask

  initial begin : pt_memory_model
    int delay;
    pt_ack_i  = 1'b0;
    pt_data_i = '0;
    forever begin
      @(negedge clk_i);
      if (pt_req_o) begin
        delay = int'($unsigned($random(seed)) % 4);
        repeat (delay) @(negedge clk_i);
        pt_data_i = mem_read(pt_addr_o);
        pt_ack_i  = 1'b1;
        do @(negedge clk_i); while (pt_req_o);
        pt_ack_i = 1'b0;
        pt_reads++;
      end
    end
  end

  task automatic check_paddr(mmu_addr_pkg::paddr_t got, mmu_addr_pkg::paddr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: paddr_o = 0x%08h, expected 0x%08h", $time, got, exp);
    end
  endtask

  task automatic check_fault(logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: fault_o = %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_walk_reads(int got, int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("** Error at %0t ns: pt_reads = %0d, expected %0d", $time, got, exp);
    end
  endtask

  // One full four-phase request, then compare the result
  task automatic access(mmu_addr_pkg::vaddr_t va, logic st, logic exp_fault,
                        mmu_addr_pkg::paddr_t exp_pa, int exp_reads);
    mmu_addr_pkg::paddr_t pa;
    logic                 flt;
    @(negedge clk_i);
    pt_reads = 0;
    vaddr_i  = va;
    store_i  = st;
    req_i    = 1'b1;
    do @(negedge clk_i); while (!ack_o);
    pa    = paddr_o;
    flt   = fault_o;
    req_i = 1'b0;
    do @(negedge clk_i); while (ack_o);
    check_paddr(pa, exp_pa);
    check_fault(flt, exp_fault);
    check_walk_reads(pt_reads, exp_reads);
  endtask

  task automatic flush_tlb();
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  task automatic test_translation_off();
    mmu_addr_pkg::vaddr_t va;
    va = make_va(10'h3ff, 10'h155, 12'habc);
    access(va, 1'b0, 1'b0, mmu_addr_pkg::paddr_t'(va), 0);
    va = make_va(10'h001, 10'h002, 12'h004);
    access(va, 1'b1, 1'b0, mmu_addr_pkg::paddr_t'(va), 0);
  endtask

  task automatic test_map_and_hit();
    mmu_addr_pkg::vaddr_t va;
    @(negedge clk_i);
    translation_en_i = 1'b1;
    va = make_va(10'd1, 10'd1, 12'h234);
    map_page(va, 20'h00100, 20'h12345, FL_V | FL_R | FL_W);
    access(va, 1'b0, 1'b0, page_addr(20'h12345, va), 2);
    access(va, 1'b0, 1'b0, page_addr(20'h12345, va), 0);
  endtask

  task automatic test_permissions();
    mmu_addr_pkg::vaddr_t va;
    va = make_va(10'd1, 10'd2, 12'h018);
    map_page(va, 20'h00100, 20'h22222, FL_V | FL_R);
    access(va, 1'b1, 1'b1, '0, 2);
    access(va, 1'b0, 1'b0, page_addr(20'h22222, va), 0);
  endtask

  task automatic test_walk_faults();
    mmu_addr_pkg::vaddr_t va_inv1;
    mmu_addr_pkg::vaddr_t va_leaf1;
    mmu_addr_pkg::vaddr_t va_inv0;
    va_inv1  = make_va(10'd5, 10'd0, 12'h100);
    va_leaf1 = make_va(10'd6, 10'd0, 12'h200);
    va_inv0  = make_va(10'd7, 10'd3, 12'h300);
    map_page(va_inv1, 20'h00200, 20'h11111, FL_V | FL_R | FL_W);
    // Level-1 pointer with V clear over a fully valid level-0 table
    pt_mem[table_addr(ROOT_PPN, 10'd5)] = leaf_pte(20'h00200, 8'h00);
    pt_mem[table_addr(ROOT_PPN, 10'd6)] = leaf_pte(20'h0abcd, FL_V | FL_R);
    map_page(va_inv0, 20'h00300, 20'h33333, FL_R | FL_W);
    // Faults are never cached, so the second pass walks again
    for (int n = 0; n < 2; n++) begin
      access(va_inv1, 1'b0, 1'b1, '0, 1);
      access(va_leaf1, 1'b0, 1'b1, '0, 1);
      access(va_inv0, 1'b0, 1'b1, '0, 2);
    end
  endtask

  task automatic test_flush();
    mmu_addr_pkg::vaddr_t va;
    va = make_va(10'd1, 10'd1, 12'h234);
    map_page(va, 20'h00100, 20'h54321, FL_V | FL_R | FL_W);
    access(va, 1'b0, 1'b0, page_addr(20'h12345, va), 0);
    flush_tlb();
    access(va, 1'b0, 1'b0, page_addr(20'h54321, va), 2);
  endtask

  task automatic test_eviction();
    mmu_addr_pkg::vaddr_t va [TLB_ENTRIES+1];
    flush_tlb();
    for (int i = 0; i <= TLB_ENTRIES; i++) begin
      va[i] = make_va(10'd8, 10'(i), 12'h0c0);
      map_page(va[i], 20'h00400, 20'h30000 + 20'(i), FL_V | FL_R | FL_W);
    end
    for (int i = 0; i <= TLB_ENTRIES; i++) begin
      access(va[i], 1'b0, 1'b0, page_addr(20'h30000 + 20'(i), va[i]), 2);
    end
    access(va[TLB_ENTRIES], 1'b0, 1'b0,
           page_addr(20'h30000 + 20'(TLB_ENTRIES), va[TLB_ENTRIES]), 0);
    access(va[0], 1'b0, 1'b0, page_addr(20'h30000, va[0]), 2);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, a handshake never completed",
             WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin
    reset_i          = 1'b1;
    translation_en_i = 1'b0;
    satp_ppn_i       = ROOT_PPN;
    flush_i          = 1'b0;
    req_i            = 1'b0;
    vaddr_i          = '0;
    store_i          = 1'b0;
    checks           = 0;
    errors           = 0;
    pt_reads         = 0;
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;

    test_translation_off();
    test_map_and_hit();
    test_permissions();
    test_walk_faults();
    test_flush();
    test_eviction();

    $display("Finished: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, mmu_top_i.assertions_i.fail_count);
    if (errors == 0 && mmu_top_i.assertions_i.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- verilog/mmu_addr_pkg.sv
//////////////////////////////////////////////////////////////////////
// MMU address definitions
// Widths and field layout of virtual and physical addresses for the
// Sv32-like two-level translation scheme
//////////////////////////////////////////////////////////////////////

package mmu_addr_pkg;

  localparam int PAGE_BITS  = 12;
  localparam int VPN_BITS   = 10;
  localparam int PPN_BITS   = 20;
  localparam int PADDR_BITS = 32;

  // Physical page number, as found in a PTE and in satp
  typedef logic [PPN_BITS-1:0] ppn_t;

  // TLB tag, vpn1 followed by vpn0
  typedef logic [2*VPN_BITS-1:0] vpn_t;

  typedef logic [PADDR_BITS-1:0] paddr_t;

  // Virtual address split into table indices and page offset
  typedef struct packed {
    logic [VPN_BITS-1:0]  vpn1;
    logic [VPN_BITS-1:0]  vpn0;
    logic [PAGE_BITS-1:0] offset;
  } vaddr_t;

endpackage

//--- verilog/mmu_ctrl.sv
//////////////////////////////////////////////////////////////////////
// MMU controller
// Requester handshake, TLB lookup, walker start and TLB fill on a
// miss, and the load and store permission check
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module mmu_ctrl (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 translation_en_i,
  input  logic                 req_i,
  input  mmu_addr_pkg::vaddr_t vaddr_i,
  input  logic                 store_i,
  output logic                 ack_o,
  output mmu_addr_pkg::paddr_t paddr_o,
  output logic                 fault_o,
  tlb_if.ctrl                  tlb,
  walk_if.ctrl                 walk
);

  localparam logic [2:0] ST_IDLE   = 3'd0;
  localparam logic [2:0] ST_CHECK  = 3'd1;
  localparam logic [2:0] ST_LOOKUP = 3'd2;
  localparam logic [2:0] ST_WALK   = 3'd3;
  localparam logic [2:0] ST_RESP   = 3'd4;

  logic [2:0]             state_r;
  mmu_addr_pkg::vaddr_t   vaddr_r;
  logic                   store_r;

  mmu_addr_pkg::vpn_t     vpn;
  mmu_pte_pkg::pte_leaf_t res_leaf;
  logic                   walk_fault;
  logic                   res_fault;
  mmu_addr_pkg::paddr_t   res_paddr;

  assign vpn = {vaddr_r.vpn1, vaddr_r.vpn0};

  assign tlb.lookup_v   = (state_r == ST_CHECK) && translation_en_i;
  assign tlb.lookup_vpn = vpn;

  assign walk.start    = (state_r == ST_LOOKUP) && tlb.hit_v && !tlb.hit;
  assign walk.walk_vpn = vpn;
  assign walk_fault    = walk.fault != mmu_pte_pkg::e_fault_none;

  // Leaves that only fail the permission check are still cached
  assign tlb.fill_v    = (state_r == ST_WALK) && walk.done && !walk_fault;
  assign tlb.fill_vpn  = vpn;
  assign tlb.fill_leaf = walk.leaf;

  // Leaf from the TLB on a hit, from the walker otherwise
  assign res_leaf  = (state_r == ST_WALK) ? walk.leaf : tlb.hit_leaf;
  assign res_fault = ((state_r == ST_WALK) && walk_fault) ||
                     (store_r ? !res_leaf.flags.w : !res_leaf.flags.r);
  assign res_paddr = res_fault ? '0 : {res_leaf.ppn, vaddr_r.offset};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= ST_IDLE;
      ack_o   <= 1'b0;
      fault_o <= 1'b0;
      paddr_o <= '0;
    end else begin
      case (state_r)
        ST_IDLE: begin
          if (req_i) state_r <= ST_CHECK;
        end
        ST_CHECK: begin
          if (!translation_en_i) begin
            ack_o   <= 1'b1;
            fault_o <= 1'b0;
            paddr_o <= vaddr_r;
            state_r <= ST_RESP;
          end else begin
            state_r <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (tlb.hit_v && tlb.hit) begin
            ack_o   <= 1'b1;
            fault_o <= res_fault;
            paddr_o <= res_paddr;
            state_r <= ST_RESP;
          end else if (tlb.hit_v) begin
            state_r <= ST_WALK;
          end
        end
        ST_WALK: begin
          if (walk.done) begin
            ack_o   <= 1'b1;
            fault_o <= res_fault;
            paddr_o <= res_paddr;
            state_r <= ST_RESP;
          end
        end
        ST_RESP: begin
          // Result held until the requester lets go
          if (!req_i) begin
            ack_o   <= 1'b0;
            state_r <= ST_IDLE;
          end
        end
        default: state_r <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == ST_IDLE && req_i) begin
      vaddr_r <= vaddr_i;
      store_r <= store_i;
    end
  end

endmodule

//--- verilog/mmu_ifs.sv
//////////////////////////////////////////////////////////////////////
// MMU internal interfaces
// TLB lookup and fill port, and the walker start and result port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface tlb_if;

  // Lookup, result one cycle later
  logic                    lookup_v;
  mmu_addr_pkg::vpn_t      lookup_vpn;
  logic                    hit_v;
  logic                    hit;
  mmu_pte_pkg::pte_leaf_t  hit_leaf;

  // Single cycle write of one entry
  logic                    fill_v;
  mmu_addr_pkg::vpn_t      fill_vpn;
  mmu_pte_pkg::pte_leaf_t  fill_leaf;

  modport ctrl (
    output lookup_v, lookup_vpn, fill_v, fill_vpn, fill_leaf,
    input  hit_v, hit, hit_leaf
  );

  modport tlb (
    input  lookup_v, lookup_vpn, fill_v, fill_vpn, fill_leaf,
    output hit_v, hit, hit_leaf
  );

endinterface

interface walk_if;

  logic                     start;
  mmu_addr_pkg::vpn_t       walk_vpn;
  logic                     done;
  mmu_pte_pkg::walk_fault_e fault;
  mmu_pte_pkg::pte_leaf_t   leaf;

  modport ctrl (output start, walk_vpn, input done, fault, leaf);

  modport ptw (input start, walk_vpn, output done, fault, leaf);

endinterface

//--- verilog/mmu_pte_pkg.sv
//////////////////////////////////////////////////////////////////////
// Page table entry definitions
// PTE flag layout, the leaf and pointer views of a PTE word, and the
// fault codes reported by the page table walker
//////////////////////////////////////////////////////////////////////

package mmu_pte_pkg;

  // Flags in PTE bits 7 to 0
  typedef struct packed {
    logic d;
    logic a;
    logic g;
    logic u;
    logic x;
    logic w;
    logic r;
    logic v;
  } pte_flags_t;

  typedef struct packed {
    mmu_addr_pkg::ppn_t ppn;
    logic [3:0]         rsv;
    pte_flags_t         flags;
  } pte_leaf_t;

  // Non-leaf entry, R, W and X are all zero
  typedef struct packed {
    mmu_addr_pkg::ppn_t next_ppn;
    logic [3:0]         rsv;
    pte_flags_t         flags;
  } pte_ptr_t;

  typedef union packed {
    pte_leaf_t leaf;
    pte_ptr_t  ptr;
  } pte_u;

  typedef enum logic [2:0] {
    e_fault_none       = 3'd0,
    e_fault_invalid_l1 = 3'd1,
    e_fault_leaf_l1    = 3'd2,
    e_fault_invalid_l0 = 3'd3,
    e_fault_ptr_l0     = 3'd4
  } walk_fault_e;

endpackage

//--- verilog/mmu_ptw.sv
//////////////////////////////////////////////////////////////////////
// Page table walker
// Two-level walk over a four-phase req/ack page table port, ending in
// a leaf PTE or a walk fault
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module mmu_ptw (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  mmu_addr_pkg::ppn_t   satp_ppn_i,
  walk_if.ptw                  walk,
  output logic                 pt_req_o,
  output mmu_addr_pkg::paddr_t pt_addr_o,
  input  logic                 pt_ack_i,
  input  logic [31:0]          pt_data_i
);

  localparam int VB = mmu_addr_pkg::VPN_BITS;

  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_L1_REQ  = 3'd1;
  localparam logic [2:0] ST_L1_WAIT = 3'd2;
  localparam logic [2:0] ST_L0_REQ  = 3'd3;
  localparam logic [2:0] ST_L0_WAIT = 3'd4;

  logic [2:0]         state_r;
  logic [VB-1:0]      vpn0_r;
  mmu_pte_pkg::pte_u  pte_r;

  logic               pte_rwx;

  assign pte_rwx = pte_r.leaf.flags.r | pte_r.leaf.flags.w | pte_r.leaf.flags.x;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= ST_IDLE;
      pt_req_o  <= 1'b0;
      walk.done <= 1'b0;
    end else begin
      walk.done <= 1'b0;
      case (state_r)
        ST_IDLE: begin
          if (walk.start) begin
            pt_req_o <= 1'b1;
            state_r  <= ST_L1_REQ;
          end
        end
        ST_L1_REQ, ST_L0_REQ: begin
          if (pt_ack_i) begin
            pt_req_o <= 1'b0;
            state_r  <= (state_r == ST_L1_REQ) ? ST_L1_WAIT : ST_L0_WAIT;
          end
        end
        ST_L1_WAIT: begin
          // Handshake complete once ack falls
          if (!pt_ack_i) begin
            if (!pte_r.ptr.flags.v || pte_rwx) begin
              walk.done <= 1'b1;
              state_r   <= ST_IDLE;
            end else begin
              pt_req_o <= 1'b1;
              state_r  <= ST_L0_REQ;
            end
          end
        end
        ST_L0_WAIT: begin
          if (!pt_ack_i) begin
            walk.done <= 1'b1;
            state_r   <= ST_IDLE;
          end
        end
        default: state_r <= ST_IDLE;
      endcase
    end
  end

  // Address, PTE capture and result
  always_ff @(posedge clk_i) begin
    if (state_r == ST_IDLE && walk.start) begin
      vpn0_r    <= walk.walk_vpn[VB-1:0];
      pt_addr_o <= {satp_ppn_i, walk.walk_vpn[2*VB-1:VB], 2'b00};
    end
    if ((state_r == ST_L1_REQ || state_r == ST_L0_REQ) && pt_ack_i) begin
      pte_r <= pt_data_i;
    end
    if (state_r == ST_L1_WAIT && !pt_ack_i) begin
      pt_addr_o  <= {pte_r.ptr.next_ppn, vpn0_r, 2'b00};
      walk.fault <= !pte_r.ptr.flags.v ? mmu_pte_pkg::e_fault_invalid_l1 :
                    pte_rwx            ? mmu_pte_pkg::e_fault_leaf_l1    :
                                         mmu_pte_pkg::e_fault_none;
    end
    if (state_r == ST_L0_WAIT && !pt_ack_i) begin
      walk.leaf  <= pte_r.leaf;
      walk.fault <= !pte_r.leaf.flags.v ? mmu_pte_pkg::e_fault_invalid_l0 :
                    !pte_rwx            ? mmu_pte_pkg::e_fault_ptr_l0     :
                                          mmu_pte_pkg::e_fault_none;
    end
  end

endmodule

//--- verilog/mmu_tlb.sv
//////////////////////////////////////////////////////////////////////
// Data TLB
// Fully associative translation cache with registered lookup,
// round-robin replacement once full, and single cycle flush
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module mmu_tlb #(
  parameter int TLB_ENTRIES = 4
) (
  input logic clk_i,
  input logic reset_i,
  input logic flush_i,
  tlb_if.tlb  tlb
);

  localparam int IDX_BITS = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  logic [TLB_ENTRIES-1:0]  valid_r;
  mmu_addr_pkg::vpn_t      tag_r  [TLB_ENTRIES];
  mmu_pte_pkg::pte_leaf_t  leaf_r [TLB_ENTRIES];
  logic [IDX_BITS-1:0]     rr_ptr_r;

  logic                    match_any;
  mmu_pte_pkg::pte_leaf_t  match_leaf;
  logic                    free_found;
  logic [IDX_BITS-1:0]     free_idx;
  logic [IDX_BITS-1:0]     victim_idx;

  // Tag compare over all entries
  always_comb begin
    match_any  = 1'b0;
    match_leaf = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (valid_r[i] && tag_r[i] == tlb.lookup_vpn) begin
        match_any  = 1'b1;
        match_leaf = leaf_r[i];
      end
    end
  end

  // Lowest free entry wins
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (!valid_r[i]) begin
        free_found = 1'b1;
        free_idx   = IDX_BITS'(i);
      end
    end
  end

  assign victim_idx = free_found ? free_idx : rr_ptr_r;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_r  <= '0;
      rr_ptr_r <= '0;
    end else if (tlb.fill_v) begin
      valid_r[victim_idx] <= 1'b1;
      if (!free_found) begin
        rr_ptr_r <= (rr_ptr_r == IDX_BITS'(TLB_ENTRIES - 1)) ? '0 : rr_ptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tlb.fill_v) begin
      tag_r[victim_idx]  <= tlb.fill_vpn;
      leaf_r[victim_idx] <= tlb.fill_leaf;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tlb.hit_v <= 1'b0;
      tlb.hit   <= 1'b0;
    end else begin
      tlb.hit_v <= tlb.lookup_v;
      tlb.hit   <= tlb.lookup_v & match_any;
    end
  end

  always_ff @(posedge clk_i) begin
    tlb.hit_leaf <= match_leaf;
  end

endmodule

//--- verilog/mmu_top.sv
//////////////////////////////////////////////////////////////////////
// Data MMU top level
// Controller, TLB and page table walker joined by internal interfaces
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module mmu_top #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 translation_en_i,
  input  mmu_addr_pkg::ppn_t   satp_ppn_i,
  input  logic                 flush_i,
  input  logic                 req_i,
  input  mmu_addr_pkg::vaddr_t vaddr_i,
  input  logic                 store_i,
  output logic                 ack_o,
  output mmu_addr_pkg::paddr_t paddr_o,
  output logic                 fault_o,
  output logic                 pt_req_o,
  output mmu_addr_pkg::paddr_t pt_addr_o,
  input  logic                 pt_ack_i,
  input  logic [31:0]          pt_data_i
);

  tlb_if  tlb_bus ();
  walk_if walk_bus ();

  mmu_ctrl ctrl_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .translation_en_i (translation_en_i),
    .req_i            (req_i),
    .vaddr_i          (vaddr_i),
    .store_i          (store_i),
    .ack_o            (ack_o),
    .paddr_o          (paddr_o),
    .fault_o          (fault_o),
    .tlb              (tlb_bus.ctrl),
    .walk             (walk_bus.ctrl)
  );

  mmu_tlb #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) tlb_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .flush_i (flush_i),
    .tlb     (tlb_bus.tlb)
  );

  mmu_ptw ptw_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .satp_ppn_i (satp_ppn_i),
    .walk       (walk_bus.ptw),
    .pt_req_o   (pt_req_o),
    .pt_addr_o  (pt_addr_o),
    .pt_ack_i   (pt_ack_i),
    .pt_data_i  (pt_data_i)
  );

endmodule
